//--- design/panel_geometry_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Panel geometry package.
// Panel size, frame buffer address widths and the pixel format.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package panel_geometry_pkg;

    // Column and row address widths.
    localparam int COLUMN_BITS = 9;  // Needs two command bytes.
    localparam int ROW_BITS = 5;     // Fits in one command byte.

    // Visible area. NUM_COLUMNS must not exceed 2**COLUMN_BITS.
    localparam int NUM_COLUMNS = 320;
    localparam int NUM_ROWS = 32;

    // Bytes the host sends for one column value, most significant first.
    localparam int COLUMN_BYTES = 2;

    // Pixel format is 8-bit red, green, blue with red in the top byte.
    localparam int BYTES_PER_PIXEL = 3;
    localparam int PIXEL_BITS = 24;

    // A frame buffer address is the row concatenated with the column.
    localparam int FB_ADDR_BITS = ROW_BITS + COLUMN_BITS;

endpackage

//--- design/command_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command package.
// Opcodes, sequencer states, APB register map and status bits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package command_pkg;

    typedef enum logic [7:0] {
        OP_FILLRECT = 8'h01,  // x1, y1, width, height, color.
        OP_CLEAR = 8'h02      // Color only.
    } opcode_t;

    typedef enum logic [3:0] {
        S_OPCODE,
        S_X1,
        S_Y1,
        S_WIDTH,
        S_HEIGHT,
        S_COLOR,
        S_START,
        S_RUNNING,
        S_DONE
    } seq_state_t;

    // APB register offsets.
    localparam logic [3:0] REG_CMD_DATA = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_PIXEL_ADDR = 4'h8;
    localparam logic [3:0] REG_PIXEL_DATA = 4'hC;

    // Bit positions in the status register.
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;
    localparam int STATUS_BADOP_BIT = 2;

endpackage

//--- design/apb_command_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave for the panel command processor.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module apb_command_port (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [7:0]  cmd_byte,
    output logic        cmd_valid,
    input  logic        ready_for_data,
    input  logic        busy,
    input  logic        done,
    input  logic        bad_opcode,
    output logic [panel_geometry_pkg::FB_ADDR_BITS-1:0] rd_addr,
    input  logic [panel_geometry_pkg::PIXEL_BITS-1:0]   rd_data
);

    logic access;
    logic cmd_write;
    logic addr_write;
    logic status_read;
    logic pixel_read;
    logic rd_wait;  // High in the second access cycle of a pixel read.
    logic done_flag;
    logic badop_flag;
    logic [panel_geometry_pkg::COLUMN_BITS-1:0] pixel_col;
    logic [panel_geometry_pkg::ROW_BITS-1:0] pixel_row;

    assign access = psel && penable;
    assign cmd_write = access && pwrite && (paddr == command_pkg::REG_CMD_DATA);
    assign addr_write = access && pwrite && (paddr == command_pkg::REG_PIXEL_ADDR);
    assign status_read = access && !pwrite && (paddr == command_pkg::REG_STATUS);
    assign pixel_read = access && !pwrite && (paddr == command_pkg::REG_PIXEL_DATA);

    // The command byte goes out on the first access cycle the sequencer can take it.
    assign cmd_byte = pwdata[7:0];
    assign cmd_valid = cmd_write && ready_for_data;
    assign pslverr = 1'b0;
    assign rd_addr = {pixel_row, pixel_col};

    always_comb begin
        pready = 1'b1;
        if (cmd_write) pready = ready_for_data;
        else if (pixel_read) pready = rd_wait;  // RAM read takes one cycle.
    end

    always_comb begin
        prdata = 32'h0;
        case (paddr)
            command_pkg::REG_STATUS: begin
                prdata[command_pkg::STATUS_BUSY_BIT] = busy;
                prdata[command_pkg::STATUS_DONE_BIT] = done_flag;
                prdata[command_pkg::STATUS_BADOP_BIT] = badop_flag;
            end
            command_pkg::REG_PIXEL_ADDR: prdata = {11'h0, pixel_row, 7'h0, pixel_col};
            command_pkg::REG_PIXEL_DATA: prdata = {8'h0, rd_data};
            default: prdata = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_wait <= 1'b0;
            done_flag <= 1'b0;
            badop_flag <= 1'b0;
            pixel_col <= '0;
            pixel_row <= '0;
        end else begin
            rd_wait <= pixel_read && !rd_wait;
            // A new event wins over a clearing status read in the same cycle.
            done_flag <= (done_flag && !status_read) || done;
            badop_flag <= (badop_flag && !status_read) || bad_opcode;
            if (addr_write) begin
                pixel_col <= pwdata[8:0];
                pixel_row <= pwdata[20:16];
            end
        end
    end

endmodule

//--- design/fillrect_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command sequencer that collects fill-rectangle and clear operands.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fillrect_sequencer (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] cmd_byte,
    input  logic       cmd_valid,
    output logic       ready_for_data,
    output logic       busy,
    output logic       done,
    output logic       bad_opcode,
    output logic       start,
    output logic [panel_geometry_pkg::COLUMN_BITS-1:0] x1,
    output logic [panel_geometry_pkg::ROW_BITS-1:0]    y1,
    output logic [panel_geometry_pkg::COLUMN_BITS-1:0] width,
    output logic [7:0]                                 height,
    output logic [panel_geometry_pkg::PIXEL_BITS-1:0]  color,
    input  logic       finished
);

    localparam int CB = panel_geometry_pkg::COLUMN_BITS;

    command_pkg::seq_state_t state;
    logic [1:0] byte_count;  // Bytes still to come for a multi-byte operand.

    assign busy = (state != command_pkg::S_OPCODE) && (state != command_pkg::S_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= command_pkg::S_OPCODE;
            byte_count <= '0;
            ready_for_data <= 1'b1;
            done <= 1'b0;
            bad_opcode <= 1'b0;
            start <= 1'b0;
            x1 <= '0;
            y1 <= '0;
            width <= '0;
            height <= '0;
            color <= '0;
        end else begin
            start <= 1'b0;
            done <= 1'b0;
            bad_opcode <= 1'b0;
            case (state)
                // S_DONE also decodes, so a byte stalled behind the run is not lost.
                command_pkg::S_OPCODE, command_pkg::S_DONE: begin
                    state <= command_pkg::S_OPCODE;
                    if (cmd_valid) begin
                        case (cmd_byte)
                            command_pkg::OP_FILLRECT: begin
                                state <= command_pkg::S_X1;
                                byte_count <= 2'(panel_geometry_pkg::COLUMN_BYTES - 1);
                            end
                            command_pkg::OP_CLEAR: begin
                                x1 <= '0;
                                y1 <= '0;
                                width <= CB'(panel_geometry_pkg::NUM_COLUMNS);
                                height <= 8'(panel_geometry_pkg::NUM_ROWS);
                                byte_count <= 2'(panel_geometry_pkg::BYTES_PER_PIXEL - 1);
                                state <= command_pkg::S_COLOR;
                            end
                            default: bad_opcode <= 1'b1;  // Byte is dropped.
                        endcase
                    end
                end
                command_pkg::S_X1: begin
                    if (cmd_valid) begin
                        x1 <= CB'({x1, cmd_byte});  // High byte first.
                        if (byte_count == 2'd0) state <= command_pkg::S_Y1;
                        else byte_count <= byte_count - 2'd1;
                    end
                end
                command_pkg::S_Y1: begin
                    if (cmd_valid) begin
                        y1 <= cmd_byte[panel_geometry_pkg::ROW_BITS-1:0];
                        byte_count <= 2'(panel_geometry_pkg::COLUMN_BYTES - 1);
                        state <= command_pkg::S_WIDTH;
                    end
                end
                command_pkg::S_WIDTH: begin
                    if (cmd_valid) begin
                        width <= CB'({width, cmd_byte});
                        if (byte_count == 2'd0) state <= command_pkg::S_HEIGHT;
                        else byte_count <= byte_count - 2'd1;
                    end
                end
                command_pkg::S_HEIGHT: begin
                    if (cmd_valid) begin
                        height <= cmd_byte;
                        byte_count <= 2'(panel_geometry_pkg::BYTES_PER_PIXEL - 1);
                        state <= command_pkg::S_COLOR;
                    end
                end
                command_pkg::S_COLOR: begin
                    if (cmd_valid) begin
                        color <= {color[15:0], cmd_byte};  // Red, green, then blue.
                        if (byte_count == 2'd0) begin
                            ready_for_data <= 1'b0;
                            state <= command_pkg::S_START;
                        end else begin
                            byte_count <= byte_count - 2'd1;
                        end
                    end
                end
                command_pkg::S_START: begin
                    start <= 1'b1;
                    state <= command_pkg::S_RUNNING;
                end
                command_pkg::S_RUNNING: begin
                    if (finished) begin
                        done <= 1'b1;
                        ready_for_data <= 1'b1;
                        x1 <= '0;
                        y1 <= '0;
                        width <= '0;
                        height <= '0;
                        color <= '0;
                        state <= command_pkg::S_DONE;
                    end
                end
                default: state <= command_pkg::S_OPCODE;
            endcase
        end
    end

endmodule

//--- design/fillarea_scanner.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scanner that writes one pixel per clock over a clipped rectangle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module fillarea_scanner (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [panel_geometry_pkg::COLUMN_BITS-1:0] x1,
    input  logic [panel_geometry_pkg::ROW_BITS-1:0]    y1,
    input  logic [panel_geometry_pkg::COLUMN_BITS-1:0] width,
    input  logic [7:0]                                 height,
    input  logic [panel_geometry_pkg::PIXEL_BITS-1:0]  color,
    output logic       wr_en,
    output logic [panel_geometry_pkg::FB_ADDR_BITS-1:0] wr_addr,
    output logic [panel_geometry_pkg::PIXEL_BITS-1:0]   wr_data,
    output logic       finished
);

    localparam int CW = panel_geometry_pkg::COLUMN_BITS + 1;

    // One bit wider than the operands so the sums cannot wrap.
    logic [CW-1:0] col_sum;
    logic [CW-1:0] col_end;
    logic [8:0] row_sum;
    logic [8:0] row_end;
    logic empty;
    logic active;
    logic [panel_geometry_pkg::COLUMN_BITS-1:0] col;
    logic [panel_geometry_pkg::ROW_BITS-1:0] row;

    assign col_sum = {1'b0, x1} + {1'b0, width};
    assign row_sum = {4'h0, y1} + {1'b0, height};
    assign col_end = (col_sum > CW'(panel_geometry_pkg::NUM_COLUMNS)) ?
                     CW'(panel_geometry_pkg::NUM_COLUMNS) : col_sum;
    assign row_end = (row_sum > 9'(panel_geometry_pkg::NUM_ROWS)) ?
                     9'(panel_geometry_pkg::NUM_ROWS) : row_sum;
    assign empty = ({1'b0, x1} >= CW'(panel_geometry_pkg::NUM_COLUMNS)) ||
                   (width == '0) || (height == 8'h0);

    assign wr_en = active;
    assign wr_addr = {row, col};
    assign wr_data = color;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            finished <= 1'b0;
            col <= '0;
            row <= '0;
        end else begin
            finished <= 1'b0;
            if (start) begin
                col <= x1;
                row <= y1;
                active <= !empty;
                finished <= empty;  // Nothing to draw.
            end else if (active) begin
                if ({1'b0, col} + CW'(1) == col_end) begin
                    col <= x1;
                    if ({4'h0, row} + 9'd1 == row_end) begin
                        active <= 1'b0;
                        finished <= 1'b1;
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

endmodule

//--- design/framebuffer_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame buffer RAM, one pixel per word, registered read.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module framebuffer_ram (
    input  logic clk,
    input  logic wr_en,
    input  logic [panel_geometry_pkg::FB_ADDR_BITS-1:0] wr_addr,
    input  logic [panel_geometry_pkg::PIXEL_BITS-1:0]   wr_data,
    input  logic [panel_geometry_pkg::FB_ADDR_BITS-1:0] rd_addr,
    output logic [panel_geometry_pkg::PIXEL_BITS-1:0]   rd_data
);

    localparam int DEPTH = 1 << panel_geometry_pkg::FB_ADDR_BITS;

    logic [panel_geometry_pkg::PIXEL_BITS-1:0] mem [0:DEPTH-1];

    // The panel powers up black.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];
    end

endmodule

//--- design/panel_command_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Panel command processor with APB port and frame buffer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module panel_command_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [7:0] cmd_byte;
    logic cmd_valid;
    logic ready_for_data;
    logic busy;
    logic done;
    logic bad_opcode;
    logic start;
    logic finished;
    logic [panel_geometry_pkg::COLUMN_BITS-1:0] x1;
    logic [panel_geometry_pkg::ROW_BITS-1:0] y1;
    logic [panel_geometry_pkg::COLUMN_BITS-1:0] width;
    logic [7:0] height;
    logic [panel_geometry_pkg::PIXEL_BITS-1:0] color;
    logic wr_en;
    logic [panel_geometry_pkg::FB_ADDR_BITS-1:0] wr_addr;
    logic [panel_geometry_pkg::PIXEL_BITS-1:0] wr_data;
    logic [panel_geometry_pkg::FB_ADDR_BITS-1:0] rd_addr;
    logic [panel_geometry_pkg::PIXEL_BITS-1:0] rd_data;

    apb_command_port port (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cmd_byte(cmd_byte), .cmd_valid(cmd_valid),
        .ready_for_data(ready_for_data), .busy(busy),
        .done(done), .bad_opcode(bad_opcode),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    fillrect_sequencer sequencer (
        .clk(clk), .reset(reset),
        .cmd_byte(cmd_byte), .cmd_valid(cmd_valid),
        .ready_for_data(ready_for_data), .busy(busy),
        .done(done), .bad_opcode(bad_opcode),
        .start(start), .x1(x1), .y1(y1), .width(width), .height(height),
        .color(color), .finished(finished)
    );

    fillarea_scanner scanner (
        .clk(clk), .reset(reset),
        .start(start), .x1(x1), .y1(y1), .width(width), .height(height),
        .color(color),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .finished(finished)
    );

    framebuffer_ram ram (
        .clk(clk),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

//--- testbench/panel_command_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB transfer, command and checking tasks for the panel testbench.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam int BUS_TIMEOUT = 20000;   // Cycles. A full clear takes about 10k.
localparam int DONE_TIMEOUT = 10000;  // Status polls.

task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error.");
endtask

task automatic check_equal(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual == expected) else begin
        $display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        abort_run();
    end
endtask

// Setup phase, then access phase until pready. Outputs are sampled at the falling edge.
task automatic apb_transfer(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int waits);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waits = 0;
    @(negedge clk);
    while (!pready) begin
        waits++;
        if (waits > BUS_TIMEOUT) begin
            $display("Timeout: pready stayed low on APB offset %h.", addr);
            abort_run();
        end
        @(negedge clk);
    end
    rdata = prdata;
    check_equal("pslverr", 32'h0, {31'h0, pslverr});
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
endtask

// Only a stalled command write may wait, and that one goes through apb_transfer.
task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    int waits;
    apb_transfer(1'b1, addr, data, unused, waits);
    check_equal("pready wait states", 32'h0, waits);
endtask

task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
    int waits;
    int expected_waits;
    expected_waits = (addr == command_pkg::REG_PIXEL_DATA) ? 1 : 0;  // RAM read latency.
    apb_transfer(1'b0, addr, 32'h0, data, waits);
    check_equal("pready wait states", expected_waits, waits);
endtask

task automatic send_byte(input logic [7:0] value);
    write_reg(command_pkg::REG_CMD_DATA, {24'h0, value});
endtask

task automatic check_pixel(input int col, input int row);
    logic [31:0] data;
    write_reg(command_pkg::REG_PIXEL_ADDR, {11'h0, 5'(row), 7'h0, 9'(col)});
    read_reg(command_pkg::REG_PIXEL_DATA, data);
    check_equal($sformatf("prdata of pixel (%0d,%0d)", col, row), {8'h0, model[row][col]}, data);
endtask

// RAM words right of the visible columns are never drawn, so they stay zero.
task automatic check_offscreen_word(input int col, input int row);
    logic [31:0] addr_value;
    logic [31:0] data;
    addr_value = {11'h0, 5'(row), 7'h0, 9'(col)};
    write_reg(command_pkg::REG_PIXEL_ADDR, addr_value);
    read_reg(command_pkg::REG_PIXEL_ADDR, data);
    check_equal("prdata of pixel address", addr_value, data);
    read_reg(command_pkg::REG_PIXEL_DATA, data);
    check_equal($sformatf("prdata of hidden word (%0d,%0d)", col, row), 32'h0, data);
endtask

// Polls the status register until the sticky done bit shows up.
task automatic wait_done();
    logic [31:0] status;
    int polls;
    polls = 0;
    status = 32'h0;
    while (!status[command_pkg::STATUS_DONE_BIT]) begin
        polls++;
        if (polls > DONE_TIMEOUT) begin
            $display("Timeout: the done status bit never came up.");
            abort_run();
        end
        read_reg(command_pkg::REG_STATUS, status);
    end
endtask

//--- testbench/panel_command_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the panel command processor.
// Sends APB commands and checks pixels against a model frame buffer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module panel_command_tb;

    localparam int NUM_COLUMNS = panel_geometry_pkg::NUM_COLUMNS;
    localparam int NUM_ROWS = panel_geometry_pkg::NUM_ROWS;

    logic clk;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [3:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic [23:0] model [0:NUM_ROWS-1][0:NUM_COLUMNS-1];  // Expected frame buffer.
    integer seed;

    panel_command_top uut (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #50 clk = ~clk;

    `include "panel_command_tasks.svh"

    // Pixels past the right or bottom edge are dropped, as the scanner clips them.
    function automatic void apply_rect(input int x, input int y, input int w, input int h,
                                       input logic [23:0] color);
        for (int r = y; r < y + h && r < NUM_ROWS; r++) begin
            for (int c = x; c < x + w && c < NUM_COLUMNS; c++) begin
                model[r][c] = color;
            end
        end
    endfunction

    task automatic send_rect_operands(input int x, input int y, input int w, input int h,
                                      input logic [23:0] color);
        send_byte(8'(x >> 8));
        send_byte(8'(x));
        send_byte(8'(y));
        send_byte(8'(w >> 8));
        send_byte(8'(w));
        send_byte(8'(h));
        send_byte(color[23:16]);
        send_byte(color[15:8]);
        send_byte(color[7:0]);
    endtask

    task automatic fill_rect(input int x, input int y, input int w, input int h,
                             input logic [23:0] color);
        send_byte(command_pkg::OP_FILLRECT);
        send_rect_operands(x, y, w, h, color);
        apply_rect(x, y, w, h, color);
        wait_done();
    endtask

    // Checks the rectangle's corners and the pixels just outside them.
    task automatic check_border(input int x, input int y, input int w, input int h);
        int cols[4];
        int rows[4];
        cols = '{x - 1, x, x + w - 1, x + w};
        rows = '{y - 1, y, y + h - 1, y + h};
        foreach (rows[i]) begin
            foreach (cols[j]) begin
                if (rows[i] >= 0 && rows[i] < NUM_ROWS && cols[j] >= 0 && cols[j] < NUM_COLUMNS)
                    check_pixel(cols[j], rows[i]);
            end
        end
    endtask

    task automatic check_grid();
        for (int r = 0; r < NUM_ROWS; r += 7) begin
            for (int c = 0; c < NUM_COLUMNS; c += 53) check_pixel(c, r);
        end
        check_pixel(NUM_COLUMNS - 1, NUM_ROWS - 1);
    endtask

    initial begin
        logic [31:0] data;
        int waits;
        int x;
        int y;
        int w;
        int h;
        logic [23:0] color;
        seed = 32'h2c18_5a77;
        clk = 1'b0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 4'h0;
        pwdata = 32'h0;
        apply_rect(0, 0, NUM_COLUMNS, NUM_ROWS, 24'h0);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        read_reg(command_pkg::REG_STATUS, data);
        check_equal("status after reset", 32'h0, data);
        check_grid();

        fill_rect(10, 4, 20, 6, 24'h12_34_56);
        check_border(10, 4, 20, 6);

        // Crosses the right and bottom edges with a column above 255.
        fill_rect(300, 28, 40, 10, 24'hA0_B0_C0);
        check_border(300, 28, 40, 10);
        check_pixel(319, 31);
        check_pixel(300, 0);  // Rows past the bottom would wrap to here.
        check_pixel(319, 5);
        check_offscreen_word(320, 28);
        check_offscreen_word(339, 31);
        check_border(10, 4, 20, 6);

        send_byte(command_pkg::OP_CLEAR);
        send_byte(8'h0F);
        send_byte(8'h1E);
        send_byte(8'h2D);
        apply_rect(0, 0, NUM_COLUMNS, NUM_ROWS, 24'h0F_1E_2D);
        read_reg(command_pkg::REG_STATUS, data);
        check_equal("status during clear", 32'h1, data);
        apb_transfer(1'b1, command_pkg::REG_CMD_DATA, {24'h0, command_pkg::OP_FILLRECT},
                     data, waits);
        assert (waits > 0) else begin
            $display("A command write during the clear completed without a wait state.");
            abort_run();
        end
        read_reg(command_pkg::REG_STATUS, data);
        check_equal("status after clear", 32'h3, data);  // Busy with the stalled opcode.
        check_grid();
        send_rect_operands(40, 10, 5, 3, 24'h55_66_77);
        apply_rect(40, 10, 5, 3, 24'h55_66_77);
        wait_done();
        check_border(40, 10, 5, 3);

        send_byte(8'h7F);
        read_reg(command_pkg::REG_STATUS, data);
        check_equal("status after bad opcode", 32'h4, data);
        read_reg(command_pkg::REG_STATUS, data);
        check_equal("status after clearing read", 32'h0, data);
        check_grid();
        fill_rect(150, 12, 33, 9, 24'hC3_5A_96);
        check_border(150, 12, 33, 9);

        for (int n = 0; n < 6; n++) begin
            x = {$random(seed)} % 340;
            y = {$random(seed)} % NUM_ROWS;
            w = {$random(seed)} % 80;
            h = {$random(seed)} % 16;
            color = 24'($random(seed));
            fill_rect(x, y, w, h, color);
            check_border(x, y, w, h);
            check_pixel({$random(seed)} % NUM_COLUMNS, {$random(seed)} % NUM_ROWS);
        end
        check_grid();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+testbench
design/panel_geometry_pkg.sv
design/command_pkg.sv
design/apb_command_port.sv
design/fillrect_sequencer.sv
design/fillarea_scanner.sv
design/framebuffer_ram.sv
design/panel_command_top.sv
testbench/panel_command_tb.sv

//--- Makefile
# Verilator build and run for the panel command processor testbench.
TOP = panel_command_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and check sim.log"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "Simulation failed."; exit 1; fi
	@grep -q "RESULT: PASS" sim.log || (echo "No pass line in sim.log."; exit 1)

clean:
	rm -rf obj_dir sim.log
